// ==== rtl/sig_verify_pkg.sv ====
`default_nettype none

package sig_verify_pkg;

	////////////////////////////////////////////////////////////
	// default sizes
	////////////////////////////////////////////////////////////

	// width of one circulant block
	localparam int BLOCK_W  = 8;
	// blocks per matrix row
	localparam int N_BLOCKS = 4;
	// row groups, one rom word each
	localparam int N_GROUPS = 4;

	// row and syndrome width
	localparam int ROW_W = BLOCK_W * N_BLOCKS;
	// signature width, one bit per scanned row
	localparam int SIG_W = BLOCK_W * N_GROUPS;

	// first rows of every circulant, one word per group
	localparam string ROM_FILE = "rtl/qc_matrix.hex";

	////////////////////////////////////////////////////////////
	// controller states
	////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		IDLE = 2'd0,
		LOAD = 2'd1,
		SCAN = 2'd2,
		DONE = 2'd3
	} verify_state_t;

endpackage

`default_nettype wire

// ==== rtl/verify_ctrl_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface verify_ctrl_if;

	// all strobes are single cycle
	logic run_start;
	logic row_load;
	logic row_rotate;
	logic acc_add;

	modport ctrl (
		output run_start,
		output row_load,
		output row_rotate,
		output acc_add
	);

	modport datapath (
		input run_start,
		input row_load,
		input row_rotate,
		input acc_add
	);

endinterface

`default_nettype wire

// ==== rtl/verify_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module verify_ctrl import sig_verify_pkg::*; #(
	parameter int  BLOCK_W  = sig_verify_pkg::BLOCK_W,
	parameter int  N_GROUPS = sig_verify_pkg::N_GROUPS,
	localparam int SIG_W    = BLOCK_W * N_GROUPS,
	localparam int ADDR_W   = (N_GROUPS > 1) ? $clog2(N_GROUPS) : 1,
	localparam int CNT_W    = (BLOCK_W > 1) ? $clog2(BLOCK_W) : 1
) (
	input  wire logic              clk,
	input  wire logic              rst_b,
	input  wire logic              start_i,
	input  wire logic [SIG_W-1:0]  sig_i,
	output logic      [ADDR_W-1:0] rom_addr_o,
	output logic                   finish_o,
	verify_ctrl_if.ctrl            ctl
);

	verify_state_t     state_q;
	verify_state_t     state_d;
	logic [SIG_W-1:0]  sig_q;
	logic [CNT_W-1:0]  scan_cnt_q;
	logic [ADDR_W-1:0] rom_addr_q;
	logic              start_ok;
	logic              last_scan;
	logic              last_group;

	// a run may start from idle or after a finished run
	assign start_ok   = start_i && ((state_q == IDLE) || (state_q == DONE));
	assign last_scan  = (scan_cnt_q == CNT_W'(BLOCK_W - 1));
	assign last_group = (rom_addr_q == ADDR_W'(N_GROUPS - 1));

	////////////////////////////////////////////////////////////
	// state machine
	////////////////////////////////////////////////////////////

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE, DONE: begin
				if (start_ok)
					state_d = LOAD;
			end
			LOAD: begin
				state_d = SCAN;
			end
			SCAN: begin
				if (last_scan)
					state_d = last_group ? DONE : LOAD;
			end
			default: begin
				state_d = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_b) begin
			state_q    <= IDLE;
			scan_cnt_q <= '0;
			rom_addr_q <= '0;
			finish_o   <= 1'b0;
		end else begin
			state_q <= state_d;
			if (start_ok) begin
				scan_cnt_q <= '0;
				rom_addr_q <= '0;
				finish_o   <= 1'b0;
			end else if (state_q == SCAN) begin
				// bit counter within one group
				scan_cnt_q <= last_scan ? '0 : scan_cnt_q + 1'b1;
				if (last_scan) begin
					rom_addr_q <= rom_addr_q + 1'b1;
					if (last_group)
						finish_o <= 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// signature scan, msb first
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (start_ok)
			sig_q <= sig_i;
		else if (state_q == SCAN)
			sig_q <= {sig_q[SIG_W-2:0], 1'b0};
	end

	// datapath strobes
	assign ctl.run_start  = start_ok;
	assign ctl.row_load   = (state_q == LOAD);
	assign ctl.row_rotate = (state_q == SCAN);
	assign ctl.acc_add    = (state_q == SCAN) && sig_q[SIG_W-1];

	assign rom_addr_o = rom_addr_q;

endmodule

`default_nettype wire

// ==== rtl/matrix_rom.sv ====
`timescale 1ns/1ns
`default_nettype none

module matrix_rom import sig_verify_pkg::*; #(
	parameter int  BLOCK_W  = sig_verify_pkg::BLOCK_W,
	parameter int  N_BLOCKS = sig_verify_pkg::N_BLOCKS,
	parameter int  N_GROUPS = sig_verify_pkg::N_GROUPS,
	localparam int ROW_W    = BLOCK_W * N_BLOCKS,
	localparam int ADDR_W   = (N_GROUPS > 1) ? $clog2(N_GROUPS) : 1
) (
	input  wire logic [ADDR_W-1:0] rom_addr_i,
	output logic      [ROW_W-1:0]  rom_row_o
);

	// one word per row group
	logic [ROW_W-1:0] rom_mem [N_GROUPS];

	initial begin
		$readmemh(ROM_FILE, rom_mem);
	end

	// no clock on the read side
	assign rom_row_o = rom_mem[rom_addr_i];

endmodule

`default_nettype wire

// ==== rtl/qc_row_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module qc_row_gen import sig_verify_pkg::*; #(
	parameter int  BLOCK_W  = sig_verify_pkg::BLOCK_W,
	parameter int  N_BLOCKS = sig_verify_pkg::N_BLOCKS,
	localparam int ROW_W    = BLOCK_W * N_BLOCKS
) (
	input  wire logic             clk,
	input  wire logic             rst_b,
	input  wire logic [ROW_W-1:0] rom_row_i,
	output logic      [ROW_W-1:0] qc_row_o,
	verify_ctrl_if.datapath       ctl
);

	logic [ROW_W-1:0] row_q;
	logic [ROW_W-1:0] row_rot;

	////////////////////////////////////////////////////////////
	// circulant shifters, one per block
	////////////////////////////////////////////////////////////

	generate
		for (genvar b = 0; b < N_BLOCKS; b++) begin : g_block
			logic [BLOCK_W-1:0] blk;

			assign blk = row_q[b*BLOCK_W +: BLOCK_W];
			// msb wraps around to lsb
			assign row_rot[b*BLOCK_W +: BLOCK_W] = {blk[BLOCK_W-2:0], blk[BLOCK_W-1]};
		end
	endgenerate

	always_ff @(posedge clk) begin
		if (!rst_b)
			row_q <= '0;
		else if (ctl.row_load)
			row_q <= rom_row_i;
		else if (ctl.row_rotate)
			row_q <= row_rot;
	end

	assign qc_row_o = row_q;

endmodule

`default_nettype wire

// ==== rtl/syndrome_acc.sv ====
`timescale 1ns/1ns
`default_nettype none

module syndrome_acc import sig_verify_pkg::*; #(
	parameter int  BLOCK_W  = sig_verify_pkg::BLOCK_W,
	parameter int  N_BLOCKS = sig_verify_pkg::N_BLOCKS,
	localparam int ROW_W    = BLOCK_W * N_BLOCKS
) (
	input  wire logic             clk,
	input  wire logic             rst_b,
	input  wire logic [ROW_W-1:0] syndrome_i,
	input  wire logic [ROW_W-1:0] qc_row_i,
	output logic                  sig_valid_o,
	verify_ctrl_if.datapath       ctl
);

	logic [ROW_W-1:0] acc_q;
	logic [ROW_W-1:0] syn_q;

	////////////////////////////////////////////////////////////
	// GF(2) accumulate
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_b) begin
			acc_q <= '0;
			syn_q <= '0;
		end else if (ctl.run_start) begin
			acc_q <= '0;
			// expected value for this run
			syn_q <= syndrome_i;
		end else if (ctl.acc_add) begin
			acc_q <= acc_q ^ qc_row_i;
		end
	end

	// only meaningful once the run has finished
	assign sig_valid_o = (acc_q == syn_q);

endmodule

`default_nettype wire

// ==== rtl/sig_verifier.sv ====
`timescale 1ns/1ns
`default_nettype none

module sig_verifier import sig_verify_pkg::*; #(
	parameter int  BLOCK_W  = sig_verify_pkg::BLOCK_W,
	parameter int  N_BLOCKS = sig_verify_pkg::N_BLOCKS,
	parameter int  N_GROUPS = sig_verify_pkg::N_GROUPS,
	localparam int ROW_W    = BLOCK_W * N_BLOCKS,
	localparam int SIG_W    = BLOCK_W * N_GROUPS,
	localparam int ADDR_W   = (N_GROUPS > 1) ? $clog2(N_GROUPS) : 1
) (
	input  wire logic             clk,
	input  wire logic             rst_b,
	input  wire logic             start_i,
	input  wire logic [SIG_W-1:0] sig_i,
	input  wire logic [ROW_W-1:0] syndrome_i,
	output logic                  sig_valid_o,
	output logic                  finish_o
);

	logic [ADDR_W-1:0] rom_addr;
	logic [ROW_W-1:0]  rom_row;
	logic [ROW_W-1:0]  qc_row;

	verify_ctrl_if u_ctrl_if ();

	////////////////////////////////////////////////////////////
	// control
	////////////////////////////////////////////////////////////

	verify_ctrl #(
		.BLOCK_W  (BLOCK_W),
		.N_GROUPS (N_GROUPS)
	) u_verify_ctrl (
		.clk        (clk),
		.rst_b      (rst_b),
		.start_i    (start_i),
		.sig_i      (sig_i),
		.rom_addr_o (rom_addr),
		.finish_o   (finish_o),
		.ctl        (u_ctrl_if.ctrl)
	);

	////////////////////////////////////////////////////////////
	// datapath
	////////////////////////////////////////////////////////////

	matrix_rom #(
		.BLOCK_W  (BLOCK_W),
		.N_BLOCKS (N_BLOCKS),
		.N_GROUPS (N_GROUPS)
	) u_matrix_rom (
		.rom_addr_i (rom_addr),
		.rom_row_o  (rom_row)
	);

	qc_row_gen #(
		.BLOCK_W  (BLOCK_W),
		.N_BLOCKS (N_BLOCKS)
	) u_qc_row_gen (
		.clk       (clk),
		.rst_b     (rst_b),
		.rom_row_i (rom_row),
		.qc_row_o  (qc_row),
		.ctl       (u_ctrl_if.datapath)
	);

	syndrome_acc #(
		.BLOCK_W  (BLOCK_W),
		.N_BLOCKS (N_BLOCKS)
	) u_syndrome_acc (
		.clk         (clk),
		.rst_b       (rst_b),
		.syndrome_i  (syndrome_i),
		.qc_row_i    (qc_row),
		.sig_valid_o (sig_valid_o),
		.ctl         (u_ctrl_if.datapath)
	);

endmodule

`default_nettype wire

// ==== bench/sig_verifier_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module sig_verifier_tb import sig_verify_pkg::*; ();

	localparam int    RESET_CYCLES = 8;
	// load plus scan cycles for every group
	localparam int    RUN_CYCLES   = N_GROUPS * (BLOCK_W + 1);
	localparam int    N_RUNS       = 21;
	localparam int    CYCLE_LIMIT  = 2 * (RESET_CYCLES + N_RUNS * (RUN_CYCLES + 4));
	localparam string MATRIX_FILE  = "rtl/qc_matrix.hex";

	logic             clk;
	logic             rst_b;
	logic             start;
	logic [SIG_W-1:0] sig;
	logic [ROW_W-1:0] syndrome;
	logic             sig_valid;
	logic             finish;

	// reference copy of the matrix
	logic [ROW_W-1:0] matrix [N_GROUPS];

	logic   run_active;
	int     run_edges;
	logic   exp_valid;
	logic   exp_finish;
	logic   checks_on;
	logic   next_valid;
	string  run_name  = "reset";
	string  next_name = "reset";
	int     cycle_cnt = 0;
	integer seed;

	// positions counted from the signature msb
	int bit_pos [8] = '{0, 5, 8, 14, 19, 22, 27, 31};

	sig_verifier #(
		.BLOCK_W  (BLOCK_W),
		.N_BLOCKS (N_BLOCKS),
		.N_GROUPS (N_GROUPS)
	) u_sig_verifier (
		.clk         (clk),
		.rst_b       (rst_b),
		.start_i     (start),
		.sig_i       (sig),
		.syndrome_i  (syndrome),
		.sig_valid_o (sig_valid),
		.finish_o    (finish)
	);

	always #2 clk = ~clk;

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////

	// bit i of every block takes bit i-r
	function automatic logic [ROW_W-1:0] turn_blocks(input logic [ROW_W-1:0] row, input int r);
		logic [ROW_W-1:0] res;
		res = '0;
		for (int b = 0; b < N_BLOCKS; b++) begin
			for (int i = 0; i < BLOCK_W; i++)
				res[b*BLOCK_W + i] = row[b*BLOCK_W + ((i - r + BLOCK_W) % BLOCK_W)];
		end
		return res;
	endfunction

	function automatic logic [ROW_W-1:0] model_syndrome(input logic [SIG_W-1:0] s);
		logic [ROW_W-1:0] acc;
		acc = '0;
		for (int p = 0; p < SIG_W; p++) begin
			if (s[SIG_W-1-p])
				acc = acc ^ turn_blocks(matrix[p / BLOCK_W], p % BLOCK_W);
		end
		return acc;
	endfunction

	function automatic logic [SIG_W-1:0] random_sig();
		logic [SIG_W-1:0] v;
		v = '0;
		for (int i = 0; i < SIG_W; i += 32)
			v = (v << 32) | SIG_W'($unsigned($random(seed)));
		return v;
	endfunction

	task automatic report_failure();
		$display("Test failed");
		$fatal(1, "run stopped at first error");
	endtask

	////////////////////////////////////////////////////////////
	// run tracking and checks
	////////////////////////////////////////////////////////////

	assign exp_finish = run_active && (run_edges >= RUN_CYCLES);

	// edges counted from the start edge
	always @(posedge clk) begin
		if (!rst_b) begin
			run_active <= 1'b0;
			run_edges  <= 0;
			checks_on  <= 1'b0;
		end else begin
			checks_on <= 1'b1;
			if (start) begin
				run_active <= 1'b1;
				run_edges  <= 0;
				exp_valid  <= next_valid;
				run_name   <= next_name;
			end else if (run_active && (run_edges < RUN_CYCLES)) begin
				run_edges <= run_edges + 1;
			end
		end
	end

	always @(negedge clk) begin
		if (checks_on) begin
			assert (finish === exp_finish) else begin
				$display("** Error [%s] finish_o expected %0b actual %0b",
					run_name, exp_finish, finish);
				report_failure();
			end
			if (exp_finish) begin
				assert (sig_valid === exp_valid) else begin
					$display("** Error [%s] sig_valid_o expected %0b actual %0b",
						run_name, exp_valid, sig_valid);
					report_failure();
				end
			end
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, the runs did not complete", cycle_cnt);
			report_failure();
		end
	end

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////

	task automatic run_case(input string name, input logic [SIG_W-1:0] s,
		input logic [ROW_W-1:0] syn);
		@(negedge clk);
		sig        = s;
		syndrome   = syn;
		start      = 1'b1;
		next_name  = name;
		next_valid = (model_syndrome(s) === syn);
		@(negedge clk);
		start = 1'b0;
		// inputs were captured at the start edge
		sig      = random_sig();
		syndrome = ROW_W'($unsigned($random(seed)));
		while (finish !== 1'b1)
			@(negedge clk);
		// result must hold while finished
		@(negedge clk);
	endtask

	initial begin
		logic [SIG_W-1:0] s;
		logic [ROW_W-1:0] syn;
		int               flip;
		seed     = 15;
		clk      = 1'b0;
		rst_b    = 1'b0;
		start    = 1'b0;
		sig      = '0;
		syndrome = '0;
		$readmemh(MATRIX_FILE, matrix);
		for (int g = 0; g < N_GROUPS; g++) begin
			if ($isunknown(matrix[g])) begin
				$display("matrix data for group %0d could not be read", g);
				report_failure();
			end
		end
		repeat (RESET_CYCLES) @(negedge clk);
		rst_b = 1'b1;
		repeat (2) @(negedge clk);

		run_case("zero_sig_zero_syn", '0, '0);
		run_case("zero_sig_bad_syn", '0, ROW_W'(32'h0000_0100));

		// one set bit per run across all groups and rotations
		foreach (bit_pos[i]) begin
			s = '0;
			s[SIG_W-1-bit_pos[i]] = 1'b1;
			run_case($sformatf("single_bit_p%0d", bit_pos[i]), s, model_syndrome(s));
		end

		repeat (4) begin
			s = random_sig();
			run_case("random_match", s, model_syndrome(s));
		end

		repeat (4) begin
			s    = random_sig();
			flip = $unsigned($random(seed)) % ROW_W;
			syn  = model_syndrome(s);
			syn[flip] = ~syn[flip];
			run_case($sformatf("random_flip_b%0d", flip), s, syn);
		end

		// restart from done with a clean accumulator
		s = random_sig();
		run_case("restart_first", s, model_syndrome(s));
		run_case("restart_stale_acc", s, '0);
		run_case("restart_zero", '0, '0);

		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// ==== rtl/qc_matrix.hex ====
// first row of every circulant block, one 32-bit word per row group
// block 3 sits in the top byte, block 0 in the bottom byte
8d2e3b61
47c1a95e
b3196d0f
2ae574c9

// ==== sig_verifier.f ====
rtl/sig_verify_pkg.sv
rtl/verify_ctrl_if.sv
rtl/verify_ctrl.sv
rtl/matrix_rom.sv
rtl/qc_row_gen.sv
rtl/syndrome_acc.sv
rtl/sig_verifier.sv
bench/sig_verifier_tb.sv
